//--- iob_wb.f
verilog/iob_wb_pkg.sv
verilog/iob_req_queue.sv
verilog/iob_iob2wishbone.sv
verilog/wb_ram.sv
verilog/iob_rdata_align.sv
verilog/iob_wb_top.sv
test/iob_wb_assertions.sv
test/iob_wb_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module iob_wb_tb -Mdir obj_dir -f iob_wb.f

# the run may return nonzero on assertion errors, the search below decides.
out=$(./obj_dir/Viob_wb_tb +verilator+error+limit+1000) || true
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"; then
   exit 0
fi
exit 1

//--- test/iob_wb_assertions.sv
module iob_wb_assertions (
   input logic                          clk_i,
   input logic                          arst_n_i,
   input logic                          iob_avalid_i,
   input logic [iob_wb_pkg::ADDR_W-1:0] iob_addr_i,
   input logic [iob_wb_pkg::DATA_W-1:0] iob_wdata_i,
   input logic [iob_wb_pkg::STRB_W-1:0] iob_wstrb_i,
   input logic                          iob_ready_o,
   input logic                          iob_rvalid_o,
   input logic [iob_wb_pkg::DATA_W-1:0] iob_rdata_o
);

   import iob_wb_pkg::*;

   logic [7:0]         shadow [MEM_WORDS*STRB_W];
   logic [DATA_W-1:0]  exp_fifo [16];
   logic [3:0]         exp_wr;
   logic [3:0]         exp_rd;
   logic [DATA_W-1:0]  exp_head;
   logic [WORD_AW+1:0] byte_base;
   logic               accept;
   logic               read_accept;
   int                 pending;
   int                 accept_run;
   int                 error_count = 0;

   assign accept      = iob_avalid_i & iob_ready_o;
   assign read_accept = accept & (iob_wstrb_i == '0);
   assign byte_base   = {iob_addr_i[WORD_AW+1:2], 2'b00};
   assign exp_head    = exp_fifo[exp_rd];

   // bytes from the offset upward, stopping at the end of the word.
   function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0]  data;
      logic [WORD_AW+1:0] idx;
      data = '0;
      for (int i = 0; i < READ_BYTES; i++) begin
         if (int'(addr[1:0]) + i < STRB_W) begin
            idx = {addr[WORD_AW+1:2], 2'b00} + (WORD_AW+2)'(int'(addr[1:0]) + i);
            data[8*i +: 8] = shadow[idx];
         end
      end
      return data;
   endfunction

   always_ff @(posedge clk_i) begin
      if (accept && iob_wstrb_i != '0) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (iob_wstrb_i[b]) begin
               shadow[byte_base + (WORD_AW+2)'(b)] <= iob_wdata_i[8*b +: 8];
            end
         end
      end
      if (read_accept) begin
         exp_fifo[exp_wr] <= expected_read(iob_addr_i);
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         exp_wr     <= '0;
         exp_rd     <= '0;
         pending    <= 0;
         accept_run <= 0;
      end else begin
         exp_wr     <= exp_wr + 4'(read_accept);
         exp_rd     <= exp_rd + 4'(iob_rvalid_o);
         pending    <= pending + int'(read_accept) - int'(iob_rvalid_o);
         accept_run <= accept ? accept_run + 1 : 0;
      end
   end

   a_reset_ready: assert property (@(posedge clk_i)
      (!arst_n_i || $rose(arst_n_i)) |-> iob_ready_o)
      else begin
         error_count++;
         $error("mismatch iob_ready_o got %h expected 1", $sampled(iob_ready_o));
      end

   a_reset_rvalid: assert property (@(posedge clk_i)
      (!arst_n_i || $rose(arst_n_i)) |-> !iob_rvalid_o)
      else begin
         error_count++;
         $error("mismatch iob_rvalid_o got %h expected 0", $sampled(iob_rvalid_o));
      end

   a_rvalid_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      iob_rvalid_o |-> pending > 0)
      else begin
         error_count++;
         $error("iob_rvalid_o pulsed while no read was pending");
      end

   a_rdata: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      iob_rvalid_o && pending > 0 |-> iob_rdata_o == exp_head)
      else begin
         error_count++;
         $error("mismatch iob_rdata_o got %h expected %h",
                $sampled(iob_rdata_o), $sampled(exp_head));
      end

   // the bridge takes one request per RAM_WAIT+2 cycles, so a longer run means a full queue.
   a_backpressure: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      accept |-> accept_run <= QUEUE_DEPTH)
      else begin
         error_count++;
         $error("iob_ready_o stayed high after the request queue filled up");
      end

endmodule

bind iob_wb_top iob_wb_assertions assertions_i (.*);

//--- test/iob_wb_tb.sv
module iob_wb_tb;

   import iob_wb_pkg::*;

   localparam int WAIT_LIMIT = 100;
   localparam int NUM_WORDS  = 6;
   localparam int BURST_LEN  = 12;

   logic              clk_i;
   logic              arst_n_i;
   logic              iob_avalid_i;
   logic [ADDR_W-1:0] iob_addr_i;
   logic [DATA_W-1:0] iob_wdata_i;
   logic [STRB_W-1:0] iob_wstrb_i;
   logic              iob_ready_o;
   logic              iob_rvalid_o;
   logic [DATA_W-1:0] iob_rdata_o;

   logic [WORD_AW-1:0] words [NUM_WORDS];
   int                 timeouts;
   int                 reads_issued;
   int                 rvalid_seen;
   int                 failures;

   iob_wb_top dut_i (.*);

   always #2 clk_i = ~clk_i;

   // responses are counted apart from the requests, which may run ahead of them.
   always @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_seen <= 0;
      end else if (iob_rvalid_o) begin
         rvalid_seen <= rvalid_seen + 1;
      end
   end

   function automatic logic [ADDR_W-1:0] byte_addr(input logic [WORD_AW-1:0] word,
                                                   input logic [1:0]         offset);
      return {{(ADDR_W - WORD_AW - 2){1'b0}}, word, offset};
   endfunction

   function automatic logic [WORD_AW-1:0] pick_word();
      return words[int'($urandom_range(NUM_WORDS - 1))];
   endfunction

   // a random strobe that selects at least one byte.
   function automatic logic [STRB_W-1:0] some_strobe();
      logic [STRB_W-1:0] strb;
      strb = STRB_W'($urandom);
      if (strb == '0) begin
         strb = STRB_W'(6);
      end
      return strb;
   endfunction

   task automatic send_request(input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata,
                               input logic [STRB_W-1:0] wstrb);
      int waited;
      waited = 0;
      @(negedge clk_i);
      iob_avalid_i = 1'b1;
      iob_addr_i   = addr;
      iob_wdata_i  = wdata;
      iob_wstrb_i  = wstrb;
      while (!iob_ready_o && waited < WAIT_LIMIT) begin
         @(negedge clk_i);
         waited++;
      end
      if (!iob_ready_o) begin
         timeouts++;
         $display("timeout waiting for iob_ready_o on address %h", addr);
      end else if (wstrb == '0) begin
         reads_issued++;
      end
      @(posedge clk_i);
   endtask

   task automatic idle_bus();
      @(negedge clk_i);
      iob_avalid_i = 1'b0;
   endtask

   task automatic drain_reads();
      int waited;
      waited = 0;
      while (rvalid_seen != reads_issued && waited < WAIT_LIMIT) begin
         @(negedge clk_i);
         waited++;
      end
      if (rvalid_seen != reads_issued) begin
         timeouts++;
         $display("timeout waiting for iob_rvalid_o, %0d of %0d reads answered",
                  rvalid_seen, reads_issued);
      end
   endtask

   initial begin
      void'($urandom(32'h581b8bd6));
      clk_i        = 1'b0;
      arst_n_i     = 1'b1;
      iob_avalid_i = 1'b0;
      iob_addr_i   = '0;
      iob_wdata_i  = '0;
      iob_wstrb_i  = '0;
      timeouts     = 0;
      reads_issued = 0;
      #1 arst_n_i = 1'b0;
      repeat (3) @(negedge clk_i);
      arst_n_i = 1'b1;

      // full words first, so that every byte read later has a known value.
      foreach (words[i]) begin
         words[i] = WORD_AW'($urandom);
         send_request(byte_addr(words[i], 2'd0), $urandom, '1);
         send_request(byte_addr(words[i], 2'd0), '0, '0);
      end
      foreach (words[i]) begin
         send_request(byte_addr(words[i], 2'd0), $urandom, some_strobe());
         send_request(byte_addr(words[i], 2'd0), '0, '0);
         send_request(byte_addr(words[i], 2'd2), '0, '0);
      end
      foreach (words[i]) begin
         for (int off = 1; off < STRB_W; off++) begin
            send_request(byte_addr(words[i], 2'(off)), '0, '0);
         end
      end
      idle_bus();
      drain_reads();

      // back-to-back mix of reads and writes, longer than the queue.
      for (int n = 0; n < BURST_LEN; n++) begin
         if ($urandom_range(1) == 0) begin
            send_request(byte_addr(pick_word(), 2'($urandom)), '0, '0);
         end else begin
            send_request(byte_addr(pick_word(), 2'd0), $urandom, some_strobe());
         end
      end
      idle_bus();
      drain_reads();
      // quiet cycles in which a stray response would show up.
      repeat (20) @(negedge clk_i);

      failures = timeouts + dut_i.assertions_i.error_count;
      $display("checks done with %0d assertion errors and %0d timeouts",
               dut_i.assertions_i.error_count, timeouts);
      if (failures == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- verilog/iob_iob2wishbone.sv
module iob_iob2wishbone (
   input  logic                          clk_i,
   input  logic                          arst_n_i,

   // IOb side.
   input  logic                          iob_avalid_i,
   input  logic [iob_wb_pkg::ADDR_W-1:0] iob_addr_i,
   input  logic [iob_wb_pkg::DATA_W-1:0] iob_wdata_i,
   input  logic [iob_wb_pkg::STRB_W-1:0] iob_wstrb_i,
   output logic                          iob_ready_o,
   output logic                          iob_rvalid_o,
   output logic [iob_wb_pkg::DATA_W-1:0] iob_rdata_o,

   // Wishbone master side.
   output logic [iob_wb_pkg::ADDR_W-1:0] wb_addr_o,
   output logic [iob_wb_pkg::STRB_W-1:0] wb_select_o,
   output logic                          wb_we_o,
   output logic                          wb_cyc_o,
   output logic                          wb_stb_o,
   output logic [iob_wb_pkg::DATA_W-1:0] wb_data_o,
   input  logic                          wb_ack_i,
   input  logic [iob_wb_pkg::DATA_W-1:0] wb_data_i
);

   import iob_wb_pkg::*;

   logic              accept;
   logic              busy_r;
   logic              we;
   logic [STRB_W-1:0] select;

   logic [ADDR_W-1:0] addr_r;
   logic [DATA_W-1:0] wdata_r;
   logic [STRB_W-1:0] select_r;
   logic              we_r;

   logic              ack_r;
   logic [DATA_W-1:0] rdata_r;

   // one bus cycle at a time; a new request waits until the cycle after ack.
   assign iob_ready_o = ~busy_r;
   assign accept      = iob_avalid_i & iob_ready_o;

   assign we     = |iob_wstrb_i;
   assign select = we ? iob_wstrb_i : READ_SEL << iob_addr_i[1:0];

   // the accepted request goes on the bus at once, then the registered copy holds it.
   assign wb_stb_o    = accept | busy_r;
   assign wb_cyc_o    = wb_stb_o;
   assign wb_addr_o   = accept ? iob_addr_i : addr_r;
   assign wb_data_o   = accept ? iob_wdata_i : wdata_r;
   assign wb_select_o = accept ? select : select_r;
   assign wb_we_o     = accept ? we : we_r;

   // writes are posted, so only a read gets a response.
   assign iob_rvalid_o = ack_r & ~we_r;
   assign iob_rdata_o  = rdata_r;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_r <= 1'b0;
         we_r   <= 1'b0;
         ack_r  <= 1'b0;
      end else begin
         if (accept) begin
            busy_r <= 1'b1;
            we_r   <= we;
         end else if (wb_ack_i) begin
            busy_r <= 1'b0;
         end
         ack_r <= wb_ack_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_r   <= iob_addr_i;
         wdata_r  <= iob_wdata_i;
         select_r <= select;
      end
      rdata_r <= wb_data_i;
   end

endmodule

//--- verilog/iob_rdata_align.sv
module iob_rdata_align (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   // byte offset of each request as it leaves the queue.
   input  logic                          req_valid_i,
   input  logic [1:0]                    req_offset_i,
   // read response from the bridge.
   input  logic                          rvalid_i,
   input  logic [iob_wb_pkg::DATA_W-1:0] rdata_i,
   output logic                          rvalid_o,
   output logic [iob_wb_pkg::DATA_W-1:0] rdata_o
);

   import iob_wb_pkg::*;

   // one cycle is outstanding past the bridge, so a single offset is kept.
   logic [1:0] offset_r;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_o <= 1'b0;
      end else begin
         rvalid_o <= rvalid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_valid_i) begin
         offset_r <= req_offset_i;
      end
      // shift the addressed byte to bit 0 and keep READ_BYTES bytes.
      if (rvalid_i) begin
         rdata_o <= (rdata_i >> {offset_r, 3'b000}) & READ_MASK;
      end
   end

endmodule

//--- verilog/iob_req_queue.sv
module iob_req_queue (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   // push side, from the IOb master.
   input  logic                          avalid_i,
   input  logic [iob_wb_pkg::ADDR_W-1:0] addr_i,
   input  logic [iob_wb_pkg::DATA_W-1:0] wdata_i,
   input  logic [iob_wb_pkg::STRB_W-1:0] wstrb_i,
   output logic                          ready_o,
   // pop side, towards the bridge.
   output logic                          avalid_o,
   output logic [iob_wb_pkg::ADDR_W-1:0] addr_o,
   output logic [iob_wb_pkg::DATA_W-1:0] wdata_o,
   output logic [iob_wb_pkg::STRB_W-1:0] wstrb_o,
   input  logic                          ready_i
);

   import iob_wb_pkg::*;

   logic [ADDR_W-1:0] addr_mem  [QUEUE_DEPTH];
   logic [DATA_W-1:0] wdata_mem [QUEUE_DEPTH];
   logic [STRB_W-1:0] wstrb_mem [QUEUE_DEPTH];

   logic [QPTR_W-1:0] wr_ptr;
   logic [QPTR_W-1:0] rd_ptr;
   logic [QCNT_W-1:0] count;
   logic              push;
   logic              pop;

   // back-pressure only once every entry is taken.
   assign ready_o  = (count != QCNT_W'(QUEUE_DEPTH));
   assign avalid_o = (count != '0);

   assign push = avalid_i & ready_o;
   assign pop  = avalid_o & ready_i;

   assign addr_o  = addr_mem[rd_ptr];
   assign wdata_o = wdata_mem[rd_ptr];
   assign wstrb_o = wstrb_mem[rd_ptr];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            if (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) begin
               wr_ptr <= '0;
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (pop) begin
            if (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         addr_mem[wr_ptr]  <= addr_i;
         wdata_mem[wr_ptr] <= wdata_i;
         wstrb_mem[wr_ptr] <= wstrb_i;
      end
   end

endmodule

//--- verilog/iob_wb_pkg.sv
package iob_wb_pkg;

   // byte addressed bus with 32-bit words.
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // request queue between the IOb port and the bridge.
   localparam int QUEUE_DEPTH = 4;
   localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
   localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

   // on-chip word memory.
   localparam int MEM_WORDS = 256;
   localparam int WORD_AW   = $clog2(MEM_WORDS);

   // wait states before ack.
   localparam int RAM_WAIT = 2;
   // at least one bit, even with no wait states.
   localparam int WAIT_W   = $clog2(RAM_WAIT + 2);

   // each read returns this many bytes, starting at the addressed byte.
   localparam int READ_BYTES = 2;

   // byte select of a read at offset 0.
   localparam logic [STRB_W-1:0] READ_SEL = STRB_W'((1 << READ_BYTES) - 1);

   // data mask applied after the read data is shifted down.
   localparam logic [DATA_W-1:0] READ_MASK =
      DATA_W'((64'd1 << (8 * READ_BYTES)) - 1);

endpackage

//--- verilog/iob_wb_top.sv
module iob_wb_top (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic                          iob_avalid_i,
   input  logic [iob_wb_pkg::ADDR_W-1:0] iob_addr_i,
   input  logic [iob_wb_pkg::DATA_W-1:0] iob_wdata_i,
   input  logic [iob_wb_pkg::STRB_W-1:0] iob_wstrb_i,
   output logic                          iob_ready_o,
   output logic                          iob_rvalid_o,
   output logic [iob_wb_pkg::DATA_W-1:0] iob_rdata_o
);

   import iob_wb_pkg::*;

   // queue to bridge.
   logic              q_avalid;
   logic [ADDR_W-1:0] q_addr;
   logic [DATA_W-1:0] q_wdata;
   logic [STRB_W-1:0] q_wstrb;
   logic              br_ready;
   logic              q_pop;

   // Wishbone bus between the bridge and the memory.
   logic [ADDR_W-1:0] wb_addr;
   logic [DATA_W-1:0] wb_data_w;
   logic [STRB_W-1:0] wb_sel;
   logic              wb_we;
   logic              wb_cyc;
   logic              wb_stb;
   logic              wb_ack;
   logic [DATA_W-1:0] wb_data_r;

   // bridge read response.
   logic              br_rvalid;
   logic [DATA_W-1:0] br_rdata;

   assign q_pop = q_avalid & br_ready;

   iob_req_queue req_queue_i (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .avalid_i(iob_avalid_i),
      .addr_i  (iob_addr_i),
      .wdata_i (iob_wdata_i),
      .wstrb_i (iob_wstrb_i),
      .ready_o (iob_ready_o),
      .avalid_o(q_avalid),
      .addr_o  (q_addr),
      .wdata_o (q_wdata),
      .wstrb_o (q_wstrb),
      .ready_i (br_ready)
   );

   iob_iob2wishbone bridge_i (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .iob_avalid_i(q_avalid),
      .iob_addr_i  (q_addr),
      .iob_wdata_i (q_wdata),
      .iob_wstrb_i (q_wstrb),
      .iob_ready_o (br_ready),
      .iob_rvalid_o(br_rvalid),
      .iob_rdata_o (br_rdata),
      .wb_addr_o   (wb_addr),
      .wb_select_o (wb_sel),
      .wb_we_o     (wb_we),
      .wb_cyc_o    (wb_cyc),
      .wb_stb_o    (wb_stb),
      .wb_data_o   (wb_data_w),
      .wb_ack_i    (wb_ack),
      .wb_data_i   (wb_data_r)
   );

   wb_ram ram_i (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .wb_addr_i  (wb_addr),
      .wb_data_i  (wb_data_w),
      .wb_select_i(wb_sel),
      .wb_we_i    (wb_we),
      .wb_cyc_i   (wb_cyc),
      .wb_stb_i   (wb_stb),
      .wb_ack_o   (wb_ack),
      .wb_data_o  (wb_data_r)
   );

   iob_rdata_align align_i (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_valid_i (q_pop),
      .req_offset_i(q_addr[1:0]),
      .rvalid_i    (br_rvalid),
      .rdata_i     (br_rdata),
      .rvalid_o    (iob_rvalid_o),
      .rdata_o     (iob_rdata_o)
   );

endmodule

//--- verilog/wb_ram.sv
module wb_ram (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic [iob_wb_pkg::ADDR_W-1:0] wb_addr_i,
   input  logic [iob_wb_pkg::DATA_W-1:0] wb_data_i,
   input  logic [iob_wb_pkg::STRB_W-1:0] wb_select_i,
   input  logic                          wb_we_i,
   input  logic                          wb_cyc_i,
   input  logic                          wb_stb_i,
   output logic                          wb_ack_o,
   output logic [iob_wb_pkg::DATA_W-1:0] wb_data_o
);

   import iob_wb_pkg::*;

   logic [DATA_W-1:0]  mem [MEM_WORDS];

   logic [WORD_AW-1:0] word_idx;
   logic [WAIT_W-1:0]  wait_cnt;
   logic               req;
   logic               last;

   // byte address to word index; bits above the memory size are ignored.
   assign word_idx = wb_addr_i[WORD_AW+1:2];

   // a cycle is pending until its ack has been given.
   assign req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign last = req & (wait_cnt == WAIT_W'(RAM_WAIT));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wait_cnt <= '0;
         wb_ack_o <= 1'b0;
      end else if (last) begin
         wait_cnt <= '0;
         wb_ack_o <= 1'b1;
      end else if (req) begin
         wait_cnt <= wait_cnt + 1'b1;
      end else begin
         wait_cnt <= '0;
         wb_ack_o <= 1'b0;
      end
   end

   // read data is loaded so that it is valid together with ack.
   always_ff @(posedge clk_i) begin
      if (last && !wb_we_i) begin
         wb_data_o <= mem[word_idx];
      end
   end

   // write happens in the ack cycle, byte by byte.
   always_ff @(posedge clk_i) begin
      if (wb_ack_o && wb_stb_i && wb_we_i) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wb_select_i[b]) begin
               mem[word_idx][8*b +: 8] <= wb_data_i[8*b +: 8];
            end
         end
      end
   end

endmodule
